// ==== Makefile ====
VERILATOR ?= verilator
TOP       := icrc_insert_tb
RTL_TOP   := icrc_insert_top
FILELIST  := sim.f
FLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/icrc_insert_checker.sv ====
`timescale 1ns/100ps

module icrc_insert_checker (
  input logic                          clk,
  input logic                          rst,
  input icrc_stream_pkg::beat_data_t   m_tdata,
  input icrc_stream_pkg::beat_keep_t   m_tkeep,
  input logic                          m_tvalid,
  input logic                          m_tready,
  input logic                          m_tlast,
  input logic                          m_tuser,
  input icrc_stream_pkg::append_state_t ap_state,
  input logic                          crc_push,
  input logic                          crc_wr_ready
);
  import icrc_stream_pkg::*;

  int unsigned fail_count = 0;

  a_reset_quiet: assert property (@(posedge clk) rst |=> !m_tvalid)
    else begin
      $error("m_tvalid high right after a reset cycle");
      fail_count++;
    end

  // stalled beat must not change
  a_hold: assert property (@(posedge clk) disable iff (rst)
    m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tkeep) &&
                              $stable(m_tlast) && $stable(m_tuser))
    else begin
      $error("output beat changed while stalled");
      fail_count++;
    end

  a_keep_contig: assert property (@(posedge clk) disable iff (rst)
    m_tvalid |-> (m_tkeep != '0) && ((beat_keep_t'(m_tkeep + 1'b1) & m_tkeep) == '0))
    else begin
      $error("output keep not contiguous from lane 0");
      fail_count++;
    end

  a_crc_room: assert property (@(posedge clk) disable iff (rst) crc_push |-> crc_wr_ready)
    else begin
      $error("crc fifo pushed while full");
      fail_count++;
    end

  // sink ready last cycle gives the skid room for the spill beat
  a_spill_drain: assert property (@(posedge clk) disable iff (rst)
    ap_state == st_spill && $past(m_tready) |=> ap_state == st_idle)
    else begin
      $error("spill beat held back although the sink was ready");
      fail_count++;
    end

endmodule

bind icrc_insert_top icrc_insert_checker checker_i (
  .clk(clk),
  .rst(rst),
  .m_tdata(m_tdata),
  .m_tkeep(m_tkeep),
  .m_tvalid(m_tvalid),
  .m_tready(m_tready),
  .m_tlast(m_tlast),
  .m_tuser(m_tuser),
  .ap_state(append_i.state_q),
  .crc_push(eng_push),
  .crc_wr_ready(crc_fifo_i.wr_ready)
);

// ==== bench/icrc_insert_tb.sv ====
`timescale 1ns/100ps
`include "icrc_macros.svh"

module icrc_insert_tb;
  import icrc_stream_pkg::*;
  import icrc_crc_pkg::*;

  localparam int LANES = `ICRC_LANES;
  localparam int WAIT_LIMIT = 2000;

  logic       clk;
  logic       rst;
  beat_data_t s_tdata;
  beat_keep_t s_tkeep;
  logic       s_tvalid;
  logic       s_tready;
  logic       s_tlast;
  beat_user_t s_tuser;
  beat_data_t m_tdata;
  beat_keep_t m_tkeep;
  logic       m_tvalid;
  logic       m_tready;
  logic       m_tlast;
  logic       m_tuser;
  logic       busy;

  // payload and frame choice stream
  logic [31:0] lcg_state;
  // sink ready stream
  logic [31:0] ready_lcg;
  logic        random_ready;
  logic        busy_seen;
  logic        run_done;
  int          error_count;
  int          test_errors;
  int          tests_run;

  // expected output beats, oldest first
  beat_data_t exp_data[$];
  beat_keep_t exp_keep[$];
  logic       exp_last[$];
  logic       exp_user[$];
  // payload of the frame being built and sent
  logic [7:0] frame[$];

  icrc_insert_top dut_i (
    .clk(clk), .rst(rst),
    .s_tdata(s_tdata), .s_tkeep(s_tkeep), .s_tvalid(s_tvalid), .s_tready(s_tready),
    .s_tlast(s_tlast), .s_tuser(s_tuser),
    .m_tdata(m_tdata), .m_tkeep(m_tkeep), .m_tvalid(m_tvalid), .m_tready(m_tready),
    .m_tlast(m_tlast), .m_tuser(m_tuser),
    .busy(busy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function logic ready_draw();
    ready_lcg = lcg_next(ready_lcg);
    return ready_lcg[20] | ready_lcg[9];
  endfunction

  // bit-serial reflected crc, one byte
  function automatic logic [31:0] ref_crc_byte(input logic [31:0] crc, input logic [7:0] b);
    logic [31:0] c;
    logic        fb;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      fb = c[0] ^ b[i];
      c = {1'b0, c[31:1]};
      if (fb) begin
        c = c ^ `ICRC_POLY_REFL;
      end
    end
    return c;
  endfunction

  // all-ones start, then eight bytes of ones
  function automatic logic [31:0] ref_seed();
    logic [31:0] c;
    c = 32'hffffffff;
    for (int i = 0; i < 8; i++) begin
      c = ref_crc_byte(c, 8'hff);
    end
    return c;
  endfunction

  function automatic logic mask_offset(input int ofs);
    return (ofs == `ICRC_MASK_OFS_0) || (ofs == `ICRC_MASK_OFS_1) ||
           (ofs == `ICRC_MASK_OFS_2) || (ofs == `ICRC_MASK_OFS_3) ||
           (ofs == `ICRC_MASK_OFS_4) || (ofs == `ICRC_MASK_OFS_5) ||
           (ofs == `ICRC_MASK_OFS_6);
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    run_done = 1'b1;
    $finish;
  endtask

  task automatic check_data(input string name, input beat_data_t got, input beat_data_t exp);
    if (got !== exp) begin
      error_count++;
      $display("Fail %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_keep(input string name, input beat_keep_t got, input beat_keep_t exp);
    if (got !== exp) begin
      error_count++;
      $display("Fail %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      error_count++;
      $display("Fail %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_beat();
    if (exp_data.size() == 0) begin
      error_count++;
      $display("output beat appeared while no beat was expected");
    end else begin
      check_data("m_tdata", m_tdata, exp_data.pop_front());
      check_keep("m_tkeep", m_tkeep, exp_keep.pop_front());
      check_bit("m_tlast", m_tlast, exp_last.pop_front());
      check_bit("m_tuser", m_tuser, exp_user.pop_front());
    end
  endtask

  // sink side, ready pattern
  always @(posedge clk) begin
    if (random_ready) begin
      m_tready <= ready_draw();
    end else begin
      m_tready <= 1'b1;
    end
  end

  always @(negedge clk) begin
    if (!rst) begin
      if (busy) begin
        busy_seen = 1'b1;
      end
      if (m_tvalid && m_tready) begin
        check_beat();
      end
    end
  end

  task automatic make_frame(input int len);
    frame.delete();
    for (int i = 0; i < len; i++) begin
      lcg_state = lcg_next(lcg_state);
      frame.push_back(lcg_state[23:16]);
    end
  endtask

  // reference model, expected beats for the current frame
  task automatic expect_frame(input beat_user_t user);
    logic [7:0]  bytes[$];
    logic [31:0] crc;
    logic        bad;
    logic        roce;
    beat_data_t  d;
    beat_keep_t  k;
    int          pos;
    bytes = frame;
    bad = user[0];
    roce = user[1] && !bad;
    if (roce) begin
      crc = ref_seed();
      for (int i = 0; i < frame.size(); i++) begin
        crc = ref_crc_byte(crc, mask_offset(i) ? 8'hff : frame[i]);
      end
      crc = ~crc;
      for (int i = 0; i < 4; i++) begin
        bytes.push_back(crc[8*i +: 8]);
      end
    end
    pos = 0;
    while (pos < bytes.size()) begin
      d = '0;
      k = '0;
      for (int i = 0; i < LANES; i++) begin
        if (pos + i < bytes.size()) begin
          d[8*i +: 8] = bytes[pos + i];
          k[i] = 1'b1;
        end
      end
      pos += LANES;
      exp_data.push_back(d);
      exp_keep.push_back(k);
      exp_last.push_back(pos >= bytes.size());
      exp_user.push_back(bad && (pos >= bytes.size()));
    end
  endtask

  // called on a rising edge, returns on the edge of the last transfer
  task automatic drive_frame(input beat_user_t user);
    beat_data_t d;
    beat_keep_t k;
    int         pos;
    int         waited;
    pos = 0;
    while (pos < frame.size()) begin
      d = '0;
      k = '0;
      for (int i = 0; i < LANES; i++) begin
        if (pos + i < frame.size()) begin
          d[8*i +: 8] = frame[pos + i];
          k[i] = 1'b1;
        end
      end
      s_tdata  <= d;
      s_tkeep  <= k;
      s_tuser  <= user;
      s_tlast  <= (pos + LANES >= frame.size());
      s_tvalid <= 1'b1;
      waited = 0;
      do begin
        @(negedge clk);
        waited++;
        if (waited > WAIT_LIMIT) begin
          abort_run("timeout: an input beat was never accepted");
        end
      end while (!s_tready);
      @(posedge clk);
      pos += LANES;
    end
  endtask

  task automatic send_frame(input int len, input beat_user_t user);
    make_frame(len);
    expect_frame(user);
    drive_frame(user);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_data.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("timeout: expected output beats never arrived");
      end
    end
    // room for stray extra beats to show up
    repeat (4) @(negedge clk);
  endtask

  task automatic start_test();
    test_errors = error_count;
    busy_seen = 1'b0;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (error_count == test_errors) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, error_count - test_errors);
    end
  endtask

  task automatic test_reset_state();
    int waited;
    start_test();
    // first reset edge, then look while reset holds
    @(posedge clk);
    repeat (4) begin
      @(negedge clk);
      check_bit("m_tvalid", m_tvalid, 1'b0);
      check_bit("busy", busy, 1'b0);
      check_bit("s_tready", s_tready, 1'b0);
    end
    @(posedge clk);
    rst <= 1'b0;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > 8) begin
        abort_run("timeout: s_tready did not rise after reset");
      end
    end while (!s_tready);
    check_bit("m_tvalid", m_tvalid, 1'b0);
    check_bit("busy", busy, 1'b0);
    end_test("reset state");
  endtask

  task automatic test_roce_no_spill();
    start_test();
    @(posedge clk);
    send_frame(36, 2'b10);
    send_frame(20, 2'b10);
    s_tvalid <= 1'b0;
    wait_drain();
    end_test("roce, crc in last beat");
  endtask

  task automatic test_roce_spill();
    start_test();
    @(posedge clk);
    send_frame(45, 2'b10);
    send_frame(48, 2'b10);
    s_tvalid <= 1'b0;
    wait_drain();
    if (!busy_seen) begin
      error_count++;
      $display("busy was never high while a spill beat was pending");
    end
    end_test("roce, crc spill beat");
  endtask

  task automatic test_plain();
    start_test();
    @(posedge clk);
    send_frame(42, 2'b00);
    s_tvalid <= 1'b0;
    wait_drain();
    end_test("non-roce pass-through");
  endtask

  task automatic test_malformed();
    start_test();
    @(posedge clk);
    // roce flag set as well, still no crc
    send_frame(30, 2'b11);
    send_frame(17, 2'b01);
    s_tvalid <= 1'b0;
    wait_drain();
    end_test("malformed pass-through");
  endtask

  task automatic test_mixed_backpressure();
    logic [31:0] r;
    start_test();
    random_ready = 1'b1;
    @(posedge clk);
    for (int f = 0; f < 10; f++) begin
      lcg_state = lcg_next(lcg_state);
      r = lcg_state;
      send_frame(1 + int'(r[15:8] % 72), beat_user_t'(r[5:4]));
    end
    s_tvalid <= 1'b0;
    wait_drain();
    random_ready = 1'b0;
    end_test("mixed frames, random back-pressure");
  endtask

  initial begin
    int total;
    lcg_state = 32'hcd88;
    ready_lcg = 32'hcd88;
    rst = 1'b1;
    s_tdata = '0;
    s_tkeep = '0;
    s_tvalid = 1'b0;
    s_tlast = 1'b0;
    s_tuser = '0;
    m_tready = 1'b0;
    random_ready = 1'b0;
    busy_seen = 1'b0;
    run_done = 1'b0;
    error_count = 0;
    test_errors = 0;
    tests_run = 0;
    test_reset_state();
    test_roce_no_spill();
    test_roce_spill();
    test_plain();
    test_malformed();
    test_mixed_backpressure();
    total = error_count + int'(dut_i.checker_i.fail_count);
    $display("tests %0d, errors %0d", tests_run, total);
    run_done = 1'b1;
    if (total == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #2000000;
    abort_run("timeout: simulation ran past its time limit");
  end

  // run stopped early, e.g. by an assertion
  final begin
    if (!run_done) begin
      $display("Verification failed");
    end
  end

endmodule

// ==== design/icrc_append.sv ====
`timescale 1ns/100ps
`include "icrc_macros.svh"

module icrc_append (
  input  logic                        clk,
  input  logic                        rst,
  input  icrc_stream_pkg::beat_data_t in_tdata,
  input  icrc_stream_pkg::beat_keep_t in_tkeep,
  input  icrc_stream_pkg::beat_user_t in_tuser,
  input  logic                        in_tvalid,
  input  logic                        in_tlast,
  output logic                        in_tready,
  input  icrc_crc_pkg::crc_t          crc_in,
  input  logic                        crc_valid,
  output logic                        crc_pop,
  output icrc_stream_pkg::beat_data_t out_tdata,
  output icrc_stream_pkg::beat_keep_t out_tkeep,
  output logic                        out_tvalid,
  output logic                        out_tlast,
  output logic                        out_tuser,
  input  logic                        out_ready,
  output logic                        busy
);
  import icrc_stream_pkg::*;
  import icrc_crc_pkg::*;

  localparam int LANES = `ICRC_LANES;

  append_state_t state_q;
  append_state_t state_next;

  crc_t       crc_inv;
  int         n_valid;
  beat_data_t splice_data;
  beat_keep_t splice_keep;
  beat_data_t spill_data_next;
  beat_keep_t spill_keep_next;
  beat_data_t spill_data_q;
  beat_keep_t spill_keep_q;
  logic       beat_ok;
  logic       roce_last;
  logic       spill_load;

  assign crc_inv   = ~crc_in;
  assign busy      = (state_q == st_spill);
  // a last beat waits for its crc
  assign beat_ok   = !in_tlast || crc_valid;
  assign roce_last = in_tlast && in_tuser[1] && !in_tuser[0];

  // crc bytes go right after the last valid lane, lsb first
  always_comb begin
    n_valid = 0;
    for (int i = 0; i < LANES; i++) begin
      if (in_tkeep[i]) begin
        n_valid = n_valid + 1;
      end
    end
    splice_data     = '0;
    splice_keep     = '0;
    spill_data_next = '0;
    spill_keep_next = '0;
    for (int i = 0; i < LANES; i++) begin
      if (i < n_valid) begin
        splice_data[8*i +: 8] = in_tdata[8*i +: 8];
        splice_keep[i]        = 1'b1;
      end else if (i < n_valid + 4) begin
        splice_data[8*i +: 8] = crc_inv[8*(i - n_valid) +: 8];
        splice_keep[i]        = 1'b1;
      end
    end
    // overflow lanes
    for (int j = 0; j < 4; j++) begin
      if (j + LANES < n_valid + 4) begin
        spill_data_next[8*j +: 8] = crc_inv[8*(j + LANES - n_valid) +: 8];
        spill_keep_next[j]        = 1'b1;
      end
    end
  end

  always_comb begin
    state_next = state_q;
    in_tready  = 1'b0;
    crc_pop    = 1'b0;
    spill_load = 1'b0;
    out_tdata  = in_tdata;
    out_tkeep  = in_tkeep;
    out_tvalid = 1'b0;
    out_tlast  = 1'b0;
    out_tuser  = 1'b0;
    case (state_q)
      st_idle, st_payload: begin
        in_tready  = out_ready && beat_ok;
        out_tvalid = in_tvalid && beat_ok;
        if (in_tlast) begin
          out_tlast = 1'b1;
          if (in_tuser[0]) begin
            out_tuser = 1'b1;
          end else if (roce_last) begin
            out_tdata = splice_data;
            out_tkeep = splice_keep;
            out_tlast = (spill_keep_next == '0);
          end
        end
        if (in_tvalid && in_tready) begin
          if (!in_tlast) begin
            state_next = st_payload;
          end else begin
            crc_pop = 1'b1;
            if (roce_last && spill_keep_next != '0) begin
              spill_load = 1'b1;
              state_next = st_spill;
            end else begin
              state_next = st_idle;
            end
          end
        end
      end
      st_spill: begin
        out_tdata  = spill_data_q;
        out_tkeep  = spill_keep_q;
        out_tvalid = 1'b1;
        out_tlast  = 1'b1;
        if (out_ready) begin
          state_next = st_idle;
        end
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    if (spill_load) begin
      spill_data_q <= spill_data_next;
      spill_keep_q <= spill_keep_next;
    end
  end

endmodule

// ==== design/icrc_crc_engine.sv ====
`timescale 1ns/100ps
`include "icrc_macros.svh"

module icrc_crc_engine (
  input  logic                        clk,
  input  logic                        rst,
  input  icrc_stream_pkg::beat_data_t masked,
  input  icrc_stream_pkg::beat_keep_t keep,
  input  logic                        fire,
  input  logic                        last,
  output icrc_crc_pkg::crc_t          crc_out,
  output logic                        crc_push
);
  import icrc_crc_pkg::*;

  localparam int LANES = `ICRC_LANES;

  crc_t crc_q;
  crc_t crc_next;

  // fold kept lanes in order, lane 0 first
  always_comb begin
    crc_next = crc_q;
    for (int i = 0; i < LANES; i++) begin
      if (keep[i]) begin
        crc_next = crc_byte_update(crc_next, masked[8*i +: 8]);
      end
    end
  end

  // final state goes out in the same cycle as the last beat
  assign crc_out  = crc_next;
  assign crc_push = fire && last;

  always_ff @(posedge clk) begin
    if (rst) begin
      crc_q <= `ICRC_SEED;
    end else if (fire) begin
      if (last) begin
        crc_q <= `ICRC_SEED;
      end else begin
        crc_q <= crc_next;
      end
    end
  end

endmodule

// ==== design/icrc_crc_pkg.sv ====
`include "icrc_macros.svh"

package icrc_crc_pkg;

  typedef logic [31:0] crc_t;

  // lsb-first crc step over one byte
  function automatic crc_t crc_byte_update(input crc_t crc, input logic [7:0] data);
    crc_t c;
    c = crc ^ {24'h000000, data};
    for (int b = 0; b < 8; b++) begin
      if (c[0]) begin
        c = (c >> 1) ^ `ICRC_POLY_REFL;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

endpackage

// ==== design/icrc_field_mask.sv ====
`timescale 1ns/100ps
`include "icrc_macros.svh"

module icrc_field_mask (
  input  logic                       clk,
  input  logic                       rst,
  input  icrc_stream_pkg::beat_data_t s_tdata,
  input  icrc_stream_pkg::beat_keep_t s_tkeep,
  input  icrc_stream_pkg::beat_user_t s_tuser,
  input  logic                       s_tvalid,
  input  logic                       s_tlast,
  output logic                       s_tready,
  output icrc_stream_pkg::beat_data_t m_tdata,
  output icrc_stream_pkg::beat_data_t m_masked,
  output icrc_stream_pkg::beat_keep_t m_tkeep,
  output icrc_stream_pkg::beat_user_t m_tuser,
  output logic                       m_tvalid,
  output logic                       m_tlast,
  input  logic                       m_tready
);
  import icrc_stream_pkg::*;

  localparam int LANES = `ICRC_LANES;

  byte_ofs_t  ofs_q;
  beat_data_t masked_next;

  function automatic logic is_masked(input byte_ofs_t o);
    return (o == `ICRC_MASK_OFS_0) || (o == `ICRC_MASK_OFS_1) ||
           (o == `ICRC_MASK_OFS_2) || (o == `ICRC_MASK_OFS_3) ||
           (o == `ICRC_MASK_OFS_4) || (o == `ICRC_MASK_OFS_5) ||
           (o == `ICRC_MASK_OFS_6);
  endfunction

  // stage moves only when the beat fifo takes
  assign s_tready = m_tready;

  always_comb begin
    masked_next = s_tdata;
    for (int i = 0; i < LANES; i++) begin
      if (is_masked(ofs_q + byte_ofs_t'(i))) begin
        masked_next[8*i +: 8] = 8'hff;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ofs_q    <= '0;
      m_tvalid <= 1'b0;
    end else if (m_tready) begin
      m_tvalid <= s_tvalid;
      if (s_tvalid) begin
        ofs_q <= s_tlast ? byte_ofs_t'(0) : ofs_q + byte_ofs_t'(LANES);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (m_tready) begin
      m_tdata  <= s_tdata;
      m_masked <= masked_next;
      m_tkeep  <= s_tkeep;
      m_tuser  <= s_tuser;
      m_tlast  <= s_tlast;
    end
  end

endmodule

// ==== design/icrc_insert_top.sv ====
`timescale 1ns/100ps
`include "icrc_macros.svh"

module icrc_insert_top (
  input  logic                        clk,
  input  logic                        rst,
  input  icrc_stream_pkg::beat_data_t s_tdata,
  input  icrc_stream_pkg::beat_keep_t s_tkeep,
  input  logic                        s_tvalid,
  output logic                        s_tready,
  input  logic                        s_tlast,
  input  icrc_stream_pkg::beat_user_t s_tuser,
  output icrc_stream_pkg::beat_data_t m_tdata,
  output icrc_stream_pkg::beat_keep_t m_tkeep,
  output logic                        m_tvalid,
  input  logic                        m_tready,
  output logic                        m_tlast,
  output logic                        m_tuser,
  output logic                        busy
);
  import icrc_stream_pkg::*;
  import icrc_crc_pkg::*;

  // fifo entry is {last, user, keep, data}
  localparam int BEAT_W = 1 + $bits(beat_user_t) + $bits(beat_keep_t) + $bits(beat_data_t);

  beat_data_t fm_data;
  beat_data_t fm_masked;
  beat_keep_t fm_keep;
  beat_user_t fm_user;
  logic       fm_valid;
  logic       fm_last;
  logic       fm_ready;

  crc_t eng_crc;
  logic eng_push;

  logic [BEAT_W-1:0] bf_rd_data;
  logic              bf_rd_valid;
  logic              bf_rd_ready;
  beat_data_t        ap_in_data;
  beat_keep_t        ap_in_keep;
  beat_user_t        ap_in_user;
  logic              ap_in_last;

  crc_t cf_data;
  logic cf_valid;
  logic cf_pop;

  beat_data_t ap_out_data;
  beat_keep_t ap_out_keep;
  logic       ap_out_valid;
  logic       ap_out_last;
  logic       ap_out_user;
  logic       skid_ready;

  assign {ap_in_last, ap_in_user, ap_in_keep, ap_in_data} = bf_rd_data;

  icrc_field_mask field_mask_i (
    .clk(clk), .rst(rst),
    .s_tdata(s_tdata), .s_tkeep(s_tkeep), .s_tuser(s_tuser),
    .s_tvalid(s_tvalid), .s_tlast(s_tlast), .s_tready(s_tready),
    .m_tdata(fm_data), .m_masked(fm_masked), .m_tkeep(fm_keep), .m_tuser(fm_user),
    .m_tvalid(fm_valid), .m_tlast(fm_last), .m_tready(fm_ready)
  );

  icrc_crc_engine crc_engine_i (
    .clk(clk), .rst(rst),
    .masked(fm_masked), .keep(fm_keep),
    .fire(fm_valid && fm_ready), .last(fm_last),
    .crc_out(eng_crc), .crc_push(eng_push)
  );

  icrc_sync_fifo #(.WIDTH(BEAT_W), .DEPTH(`ICRC_BEAT_FIFO_DEPTH)) beat_fifo_i (
    .clk(clk), .rst(rst),
    .wr_data({fm_last, fm_user, fm_keep, fm_data}), .wr_valid(fm_valid), .wr_ready(fm_ready),
    .rd_data(bf_rd_data), .rd_valid(bf_rd_valid), .rd_ready(bf_rd_ready)
  );

  // never full when pushed, see depth macros
  icrc_sync_fifo #(.WIDTH($bits(crc_t)), .DEPTH(`ICRC_CRC_FIFO_DEPTH)) crc_fifo_i (
    .clk(clk), .rst(rst),
    .wr_data(eng_crc), .wr_valid(eng_push), .wr_ready(),
    .rd_data(cf_data), .rd_valid(cf_valid), .rd_ready(cf_pop)
  );

  icrc_append append_i (
    .clk(clk), .rst(rst),
    .in_tdata(ap_in_data), .in_tkeep(ap_in_keep), .in_tuser(ap_in_user),
    .in_tvalid(bf_rd_valid), .in_tlast(ap_in_last), .in_tready(bf_rd_ready),
    .crc_in(cf_data), .crc_valid(cf_valid), .crc_pop(cf_pop),
    .out_tdata(ap_out_data), .out_tkeep(ap_out_keep), .out_tvalid(ap_out_valid),
    .out_tlast(ap_out_last), .out_tuser(ap_out_user), .out_ready(skid_ready),
    .busy(busy)
  );

  icrc_out_skid out_skid_i (
    .clk(clk), .rst(rst),
    .in_tdata(ap_out_data), .in_tkeep(ap_out_keep), .in_tvalid(ap_out_valid),
    .in_tlast(ap_out_last), .in_tuser(ap_out_user), .in_ready(skid_ready),
    .m_tdata(m_tdata), .m_tkeep(m_tkeep), .m_tvalid(m_tvalid),
    .m_tlast(m_tlast), .m_tuser(m_tuser), .m_tready(m_tready)
  );

endmodule

// ==== design/icrc_macros.svh ====
`ifndef ICRC_MACROS_SVH
`define ICRC_MACROS_SVH

// byte lanes per beat
`define ICRC_LANES 8

`define ICRC_BEAT_FIFO_DEPTH 32
// one crc slot per buffered frame at most
`define ICRC_CRC_FIFO_DEPTH `ICRC_BEAT_FIFO_DEPTH

// reflected ethernet polynomial
`define ICRC_POLY_REFL 32'hedb88320
// register after 64 bits of ones from all-ones start
`define ICRC_SEED 32'hdebb20e3

// variant fields, byte offsets from start of ipv4 header
`define ICRC_MASK_OFS_0 16'd1
`define ICRC_MASK_OFS_1 16'd8
`define ICRC_MASK_OFS_2 16'd10
`define ICRC_MASK_OFS_3 16'd11
`define ICRC_MASK_OFS_4 16'd26
`define ICRC_MASK_OFS_5 16'd27
`define ICRC_MASK_OFS_6 16'd32

`endif

// ==== design/icrc_out_skid.sv ====
`timescale 1ns/100ps

module icrc_out_skid (
  input  logic                        clk,
  input  logic                        rst,
  input  icrc_stream_pkg::beat_data_t in_tdata,
  input  icrc_stream_pkg::beat_keep_t in_tkeep,
  input  logic                        in_tvalid,
  input  logic                        in_tlast,
  input  logic                        in_tuser,
  output logic                        in_ready,
  output icrc_stream_pkg::beat_data_t m_tdata,
  output icrc_stream_pkg::beat_keep_t m_tkeep,
  output logic                        m_tvalid,
  output logic                        m_tlast,
  output logic                        m_tuser,
  input  logic                        m_tready
);
  import icrc_stream_pkg::*;

  logic       ready_q;
  logic       ready_early;
  logic       out_valid_next;
  logic       tmp_valid_q;
  logic       tmp_valid_next;
  beat_data_t tmp_data_q;
  beat_keep_t tmp_keep_q;
  logic       tmp_last_q;
  logic       tmp_user_q;
  logic       in_to_out;
  logic       in_to_tmp;
  logic       tmp_to_out;

  assign in_ready = ready_q;
  // room next cycle if sink takes now or both slots are empty
  assign ready_early = m_tready || (!tmp_valid_q && !m_tvalid);

  always_comb begin
    out_valid_next = m_tvalid;
    tmp_valid_next = tmp_valid_q;
    in_to_out      = 1'b0;
    in_to_tmp      = 1'b0;
    tmp_to_out     = 1'b0;
    if (ready_q) begin
      if (m_tready || !m_tvalid) begin
        out_valid_next = in_tvalid;
        in_to_out      = 1'b1;
      end else begin
        tmp_valid_next = in_tvalid;
        in_to_tmp      = 1'b1;
      end
    end else if (m_tready) begin
      out_valid_next = tmp_valid_q;
      tmp_valid_next = 1'b0;
      tmp_to_out     = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ready_q     <= 1'b0;
      m_tvalid    <= 1'b0;
      tmp_valid_q <= 1'b0;
    end else begin
      ready_q     <= ready_early;
      m_tvalid    <= out_valid_next;
      tmp_valid_q <= tmp_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    if (in_to_out) begin
      m_tdata <= in_tdata;
      m_tkeep <= in_tkeep;
      m_tlast <= in_tlast;
      m_tuser <= in_tuser;
    end else if (tmp_to_out) begin
      m_tdata <= tmp_data_q;
      m_tkeep <= tmp_keep_q;
      m_tlast <= tmp_last_q;
      m_tuser <= tmp_user_q;
    end
    if (in_to_tmp) begin
      tmp_data_q <= in_tdata;
      tmp_keep_q <= in_tkeep;
      tmp_last_q <= in_tlast;
      tmp_user_q <= in_tuser;
    end
  end

endmodule

// ==== design/icrc_stream_pkg.sv ====
`include "icrc_macros.svh"

package icrc_stream_pkg;

  typedef logic [`ICRC_LANES*8-1:0] beat_data_t;

  typedef logic [`ICRC_LANES-1:0] beat_keep_t;

  // bit 0 malformed, bit 1 roce
  typedef logic [1:0] beat_user_t;

  typedef logic [15:0] byte_ofs_t;

  typedef enum logic [1:0] {
    st_idle,
    st_payload,
    st_spill
  } append_state_t;

endpackage

// ==== design/icrc_sync_fifo.sv ====
`timescale 1ns/100ps

module icrc_sync_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 32
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [WIDTH-1:0] wr_data,
  input  logic             wr_valid,
  output logic             wr_ready,
  output logic [WIDTH-1:0] rd_data,
  output logic             rd_valid,
  input  logic             rd_ready
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [AW:0]      count;
  logic [AW:0]      count_next;
  logic             ready_q;
  logic             wr_fire;
  logic             rd_fire;

  assign wr_ready = ready_q;
  assign rd_valid = (count != '0);
  // first word falls through
  assign rd_data  = mem[rd_ptr];

  assign wr_fire = wr_valid && ready_q;
  assign rd_fire = rd_valid && rd_ready;

  always_comb begin
    count_next = count;
    if (wr_fire && !rd_fire) begin
      count_next = count + 1'b1;
    end else if (rd_fire && !wr_fire) begin
      count_next = count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      ready_q <= 1'b0;
    end else begin
      count   <= count_next;
      ready_q <= (count_next != (AW+1)'(DEPTH));
      if (wr_fire) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_fire) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= wr_data;
    end
  end

endmodule

// ==== sim.f ====
+incdir+design
design/icrc_stream_pkg.sv
design/icrc_crc_pkg.sv
design/icrc_field_mask.sv
design/icrc_crc_engine.sv
design/icrc_sync_fifo.sv
design/icrc_append.sv
design/icrc_out_skid.sv
design/icrc_insert_top.sv
bench/icrc_insert_checker.sv
bench/icrc_insert_tb.sv
